//--- common/mipsPkg.sv
package mipsPkg;

`include "mips_macros.svh"

    typedef logic [`WORD_W-1:0] word_t;

    ////////////////////////////////////////////////////////////////////////////
    // three views of one instruction word
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFields;

    typedef union packed {
        rFields rType;
        iFields iType;
        jFields jType;
    } instrWord;

    typedef enum logic [4:0] {
        opNop = 5'b00000, opAdd = 5'b00001, opSub = 5'b00010, opMul = 5'b00011,
        opSll = 5'b00100, opSrl = 5'b00101, opAnd = 5'b00110, opOr  = 5'b00111,
        opXor = 5'b01000, opGez = 5'b01001, opLtz = 5'b01010, opEq  = 5'b01100,
        opNor = 5'b01101, opSlt = 5'b01110, opNe  = 5'b01111, opGtz = 5'b10000,
        opLez = 5'b10001
    } aluOp;

    typedef enum logic [1:0] {
        sizeNone = 2'b00,
        sizeWord = 2'b01,
        sizeHalf = 2'b10,
        sizeByte = 2'b11
    } memSize;

    // sequencer states, one per cycle
    typedef enum logic [2:0] {sFetch, sDecode, sExec, sMem, sWrite} seqState;

endpackage

//--- common/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath word width in bits
`define WORD_W 32

// architectural register count
`define REG_COUNT 32

// unified memory depth in words
`define MEM_WORDS 1024

`endif

//--- mipsCore.f
+incdir+common
common/mipsPkg.sv
rtl/controller.sv
rtl/cycleSequencer.sv
rtl/programCounter.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/unifiedMemory.sv
rtl/mipsCore.sv
verif/tbMipsCore.sv

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu (
    input  mipsPkg::aluOp  op,
    input  mipsPkg::word_t a,
    input  mipsPkg::word_t b,
    input  logic [4:0]     shamt,
    output mipsPkg::word_t result,
    output logic           condition
);
    import mipsPkg::*;

    always_comb begin
        result    = '0;
        condition = 1'b0;
        case (op)
            opAdd: result = a + b;
            opSub: result = a - b;
            opMul: result = a * b;                      // low word kept
            opSll: result = b << shamt;
            opSrl: result = b >> shamt;
            opAnd: result = a & b;
            opOr:  result = a | b;
            opXor: result = a ^ b;
            opNor: result = ~(a | b);
            opSlt: result = word_t'($signed(a) < $signed(b));

            //////////////////////////////////////////////////////////////////////////
            // branch compares set only the flag
            //////////////////////////////////////////////////////////////////////////
            opEq:  condition = (a == b);
            opNe:  condition = (a != b);
            opGez: condition = ($signed(a) >= 0);
            opLtz: condition = ($signed(a) < 0);
            opGtz: condition = ($signed(a) > 0);
            opLez: condition = ($signed(a) <= 0);
            default: ;                                  // opNop
        endcase
    end

endmodule

//--- rtl/controller.sv
`timescale 1ns/10ps

module controller (
    input  mipsPkg::instrWord instr,
    output logic              regWrite,
    output logic              aluSrc,
    output logic              regDst,
    output logic              memToReg,
    output logic              branch,
    output logic              jump,
    output logic              jr,
    output logic              jal,
    output mipsPkg::aluOp     aluControl,
    output mipsPkg::memSize   memWrite,
    output mipsPkg::memSize   memRead,
    output logic              signedImm
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = instr.rType.opcode;
    assign funct  = instr.rType.funct;
    assign rt     = instr.iType.rt;     // regimm subcode

    // low opcode bits give the access size for loads and stores
    function automatic memSize accessSize(logic [1:0] code);
        case (code)
            2'b00:   return sizeByte;
            2'b01:   return sizeHalf;
            default: return sizeWord;
        endcase
    endfunction

    always_comb begin
        regWrite   = 1'b0;
        aluSrc     = 1'b0;
        regDst     = 1'b0;
        memToReg   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        jr         = 1'b0;
        jal        = 1'b0;
        aluControl = opNop;
        memWrite   = sizeNone;
        memRead    = sizeNone;
        signedImm  = 1'b0;
        case (opcode)
            6'b000000: begin                            // R-type
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    6'b000000: begin
                        aluControl = opSll;
                        regWrite   = (instr != '0); // all-zero word is a nop
                    end
                    6'b000010: aluControl = opSrl;
                    6'b100000: aluControl = opAdd;
                    6'b100010: aluControl = opSub;
                    6'b011000: aluControl = opMul;      // low word only
                    6'b100100: aluControl = opAnd;
                    6'b100101: aluControl = opOr;
                    6'b100110: aluControl = opXor;
                    6'b100111: aluControl = opNor;
                    6'b101010: aluControl = opSlt;
                    6'b001000: begin                    // jr
                        regWrite = 1'b0;
                        jr       = 1'b1;
                    end
                    default:   regWrite = 1'b0;
                endcase
            end
            6'b100000, 6'b100001, 6'b100011: begin      // lb, lh, lw
                regWrite   = 1'b1;
                aluSrc     = 1'b1;
                signedImm  = 1'b1;
                memToReg   = 1'b1;
                aluControl = opAdd;                     // address add
                memRead    = accessSize(opcode[1:0]);
            end
            6'b101000, 6'b101001, 6'b101011: begin      // sb, sh, sw
                aluSrc     = 1'b1;
                signedImm  = 1'b1;
                aluControl = opAdd;
                memWrite   = accessSize(opcode[1:0]);
            end
            6'b001000, 6'b001010: begin                 // addi, slti
                regWrite   = 1'b1;
                aluSrc     = 1'b1;
                signedImm  = 1'b1;
                aluControl = opcode[1] ? opSlt : opAdd;
            end
            6'b001100, 6'b001101, 6'b001110: begin      // andi, ori, xori
                regWrite   = 1'b1;
                aluSrc     = 1'b1;
                aluControl = (opcode[1:0] == 2'b00) ? opAnd :
                             (opcode[1:0] == 2'b01) ? opOr : opXor;
            end
            6'b000100: begin branch = 1'b1; aluControl = opEq;  end
            6'b000101: begin branch = 1'b1; aluControl = opNe;  end
            6'b000110: begin branch = 1'b1; aluControl = opLez; end
            6'b000111: begin branch = 1'b1; aluControl = opGtz; end
            6'b000001: begin                            // bgez, bltz by rt
                branch     = (rt == 5'b00001) || (rt == 5'b00000);
                aluControl = rt[0] ? opGez : opLtz;
            end
            6'b000010: jump = 1'b1;                     // j
            6'b000011: begin                            // jal links r31
                jump     = 1'b1;
                jal      = 1'b1;
                regWrite = 1'b1;
            end
            default: ;                                  // unknown is a nop
        endcase
    end

endmodule

//--- rtl/cycleSequencer.sv
`timescale 1ns/10ps

module cycleSequencer (
    input  logic       clk,
    input  logic       rstN,
    input  logic       run,
    input  logic       isMem,
    input  logic       isBranchOrJump,
    output logic       irLoad,
    output logic       regWrite,
    output logic       memEnable,
    output logic       pcUpdate,
    output logic       retire,
    output logic [2:0] state
);
    import mipsPkg::*;

    seqState cur;
    seqState nxt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cur <= sFetch;
        end else begin
            cur <= nxt;
        end
    end

    // a store raises both class flags and ends after sMem with no writeback
    always_comb begin
        nxt = cur;
        case (cur)
            sFetch:  if (run) nxt = sDecode;
            sDecode: nxt = sExec;
            sExec:   nxt = isMem ? sMem : (isBranchOrJump ? sFetch : sWrite);
            sMem:    nxt = isBranchOrJump ? sFetch : sWrite;
            default: nxt = sFetch;
        endcase
    end

    assign irLoad    = (cur == sFetch) && run;
    assign pcUpdate  = (cur == sExec) && isBranchOrJump && !isMem;   // redirect window
    assign memEnable = (cur == sMem);
    assign regWrite  = (cur == sWrite) || pcUpdate;                 // jal links in sExec
    assign retire    = pcUpdate || (memEnable && isBranchOrJump) || (cur == sWrite);
    assign state     = cur;

endmodule

//--- rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
    input  logic           clk,
    input  logic           rstN,
    input  logic           run,
    input  logic           loadEn,
    input  logic [9:0]     loadAddr,
    input  mipsPkg::word_t loadData,
    input  logic [4:0]     dbgReg,
    output mipsPkg::word_t dbgData,
    output mipsPkg::word_t pc,
    output logic           retire
);
    import mipsPkg::*;

    logic       irLoad, seqRegWrite, memEnable, pcUpdate;
    logic [2:0] state;
    logic       ctrlRegWrite, aluSrc, regDst, memToReg, branch, jump, jr, jal, signedImm;
    aluOp       aluControl;
    memSize     memWrite, memRead, memAccess;
    logic       isMem, storeOp, aluCond;
    logic       takeBranch, doJump, doJumpReg, advance;
    instrWord   ir;
    word_t      regA, regB, aluOut, loadReg;                // per-instruction registers
    word_t      rfA, rfB, aluResult, memRdata, memAddr;
    word_t      imm32, aluB, pcPlus4, branchOffset, jumpTarget, wbData;
    logic [4:0] wbAddr;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////
    assign storeOp = (memWrite != sizeNone);
    assign isMem   = storeOp || (memRead != sizeNone);

    cycleSequencer i_cycleSequencer (
        .clk(clk), .rstN(rstN), .run(run),
        .isMem(isMem), .isBranchOrJump(branch | jump | jr | storeOp),   // stores skip sWrite
        .irLoad(irLoad), .regWrite(seqRegWrite), .memEnable(memEnable),
        .pcUpdate(pcUpdate), .retire(retire), .state(state)
    );

    controller i_controller (
        .instr(ir), .regWrite(ctrlRegWrite), .aluSrc(aluSrc), .regDst(regDst),
        .memToReg(memToReg), .branch(branch), .jump(jump), .jr(jr), .jal(jal),
        .aluControl(aluControl), .memWrite(memWrite), .memRead(memRead),
        .signedImm(signedImm)
    );

    ////////////////////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////////////////////
    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{ir.iType.imm[15]}}, ir.iType.imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], ir.jType.target, 2'b00};
    assign takeBranch   = pcUpdate && branch && aluCond;
    assign doJump       = pcUpdate && jump;
    assign doJumpReg    = pcUpdate && jr;
    assign advance      = retire && !(takeBranch || doJump || doJumpReg);

    programCounter i_programCounter (
        .clk(clk), .rstN(rstN), .advance(advance), .branchTaken(takeBranch),
        .jump(doJump), .jumpReg(doJumpReg), .branchOffset(branchOffset),
        .target(jumpTarget), .regTarget(regA), .pc(pc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////
    assign imm32  = signedImm ? {{16{ir.iType.imm[15]}}, ir.iType.imm} : {16'b0, ir.iType.imm};
    assign aluB   = aluSrc ? imm32 : regB;
    assign wbAddr = jal ? 5'd31 : (regDst ? ir.rType.rd : ir.rType.rt);  // r31 is the link
    assign wbData = jal ? pcPlus4 : (memToReg ? loadReg : aluOut);

    registerFile i_registerFile (
        .clk(clk), .rstN(rstN), .writeEn(seqRegWrite && ctrlRegWrite),
        .readA(ir.rType.rs), .readB(ir.rType.rt), .writeAddr(wbAddr), .dbgAddr(dbgReg),
        .writeData(wbData), .dataA(rfA), .dataB(rfB), .dbgData(dbgData)
    );

    alu i_alu (
        .op(aluControl), .a(regA), .b(aluB), .shamt(ir.rType.shamt),
        .result(aluResult), .condition(aluCond)
    );

    // fetch reads at pc, sMem at the computed address
    assign memAddr   = (state == sFetch) ? pc : aluOut;
    assign memAccess = (state == sFetch) ? sizeWord : (storeOp ? memWrite : memRead);

    unifiedMemory i_unifiedMemory (
        .clk(clk), .writeEn(memEnable && storeOp), .loadEn(loadEn), .addr(memAddr),
        .size(memAccess), .writeData(regB), .loadData(loadData), .loadAddr(loadAddr),
        .readData(memRdata)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ir <= '0;                                       // starts as a nop
        end else if (irLoad) begin
            ir <= memRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == sDecode) begin
            regA <= rfA;
            regB <= rfB;
        end
        if (state == sExec) begin
            aluOut <= aluResult;
        end
        if (memEnable) begin
            loadReg <= memRdata;                            // already sign-extended
        end
    end

endmodule

//--- rtl/programCounter.sv
`timescale 1ns/10ps

module programCounter (
    input  logic           clk,
    input  logic           rstN,
    input  logic           advance,
    input  logic           branchTaken,
    input  logic           jump,
    input  logic           jumpReg,
    input  mipsPkg::word_t branchOffset,
    input  mipsPkg::word_t target,
    input  mipsPkg::word_t regTarget,
    output mipsPkg::word_t pc
);
    import mipsPkg::*;

    word_t seqPc;

    assign seqPc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (jumpReg) begin
            pc <= regTarget;                // jr
        end else if (jump) begin
            pc <= target;                   // j, jal
        end else if (branchTaken) begin
            pc <= seqPc + branchOffset;
        end else if (advance) begin
            pc <= seqPc;
        end
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module registerFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           writeEn,
    input  logic [4:0]     readA,
    input  logic [4:0]     readB,
    input  logic [4:0]     writeAddr,
    input  logic [4:0]     dbgAddr,
    input  mipsPkg::word_t writeData,
    output mipsPkg::word_t dataA,
    output mipsPkg::word_t dataB,
    output mipsPkg::word_t dbgData
);
    import mipsPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // r0 reads zero on every port
    assign dataA   = (readA == 5'd0) ? '0 : regs[readA];
    assign dataB   = (readB == 5'd0) ? '0 : regs[readB];
    assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];

endmodule

//--- rtl/unifiedMemory.sv
`timescale 1ns/10ps
`include "mips_macros.svh"

module unifiedMemory (
    input  logic            clk,
    input  logic            writeEn,
    input  logic            loadEn,
    input  mipsPkg::word_t  addr,
    input  mipsPkg::memSize size,
    input  mipsPkg::word_t  writeData,
    input  mipsPkg::word_t  loadData,
    input  logic [9:0]      loadAddr,
    output mipsPkg::word_t  readData
);
    import mipsPkg::*;

    localparam int AddrW = $clog2(`MEM_WORDS);

    word_t            mem [`MEM_WORDS];
    logic [AddrW-1:0] wordIdx;
    word_t            stored;
    word_t            merged;
    logic [7:0]       rdByte;
    logic [15:0]      rdHalf;

    assign wordIdx = addr[AddrW+1:2];                   // byte address to word
    assign stored  = mem[wordIdx];
    assign rdByte  = stored[{addr[1:0], 3'b000} +: 8];  // little-endian lanes
    assign rdHalf  = stored[{addr[1], 4'b0000} +: 16];

    // partial stores merge into the stored word
    always_comb begin
        merged = stored;
        case (size)
            sizeByte: merged[{addr[1:0], 3'b000} +: 8] = writeData[7:0];
            sizeHalf: merged[{addr[1], 4'b0000} +: 16] = writeData[15:0];
            sizeWord: merged = writeData;
            default: ;
        endcase
    end

    always_comb begin
        case (size)
            sizeByte: readData = {{24{rdByte[7]}}, rdByte};
            sizeHalf: readData = {{16{rdHalf[15]}}, rdHalf};
            default:  readData = stored;
        endcase
    end

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[AddrW'(loadAddr)] <= loadData;           // program load wins
        end else if (writeEn) begin
            mem[wordIdx] <= merged;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbMipsCore -f mipsCore.f -o simTb
./obj_dir/simTb > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
exit 0

//--- verif/tbMipsCore.sv
`timescale 1ns/10ps

module tbMipsCore;
    import mipsPkg::*;

    localparam int TotalInstr = 57;                     // retired over all tests
    localparam int CycleLimit = 5 * TotalInstr + 300;   // plus reset, load and reads

    logic       clk;
    logic       rstN;
    logic       run;
    logic       loadEn;
    logic [9:0] loadAddr;
    word_t      loadData;
    logic [4:0] dbgReg;
    word_t      dbgData;
    word_t      pc;
    logic       retire;

    word_t prog [$];                                    // program image, word 0 first
    int    errors = 0;
    int    checks = 0;
    int    cycleCount = 0;

    mipsCore i_mipsCore (
        .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .dbgReg(dbgReg), .dbgData(dbgData), .pc(pc), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoders and reference values
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t rInstr(logic [5:0] funct, logic [4:0] rd, logic [4:0] rs,
                                     logic [4:0] rt, logic [4:0] sh);
        instrWord w;
        w.rType = '{6'd0, rs, rt, rd, sh, funct};
        return w;
    endfunction

    function automatic word_t iInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                     logic [15:0] imm);
        instrWord w;
        w.iType = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic word_t jInstr(logic [5:0] op, logic [25:0] target);
        instrWord w;
        w.jType = '{op, target};
        return w;
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t sext8(logic [7:0] v);
        return {{24{v[7]}}, v};
    endfunction

    function automatic word_t refResult(aluOp op, word_t a, word_t b, logic [4:0] sh);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opMul:   return word_t'(64'(a) * 64'(b));   // low word of the product
            opSll:   return b << sh;
            opSrl:   return b >> sh;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opNor:   return ~(a | b);
            opSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic readReg(input logic [4:0] r, output word_t v);
        @(negedge clk);
        dbgReg = r;
        #1;
        v = dbgData;
    endtask

    task automatic checkWord(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkReg(string name, logic [4:0] r, word_t exp);
        word_t act;
        readReg(r, act);
        checkWord(name, exp, act);
    endtask

    task automatic checkOp(string name, logic [4:0] r, aluOp op, word_t a, word_t b,
                           logic [4:0] sh);
        word_t exp;
        word_t act;
        exp = refResult(op, a, b, sh);
        readReg(r, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s (%s, r%0d): expected %h, actual %h",
                     name, op.name(), r, exp, act);
        end
    endtask

    task automatic checkCycles(string name, int exp, int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAILED %s cycles: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program loading and stepping
    ////////////////////////////////////////////////////////////////////////////
    task automatic loadAndStart();
        @(negedge clk);
        run  = 1'b0;
        rstN = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        foreach (prog[i]) begin
            loadEn   = 1'b1;
            loadAddr = 10'(i);
            loadData = prog[i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        run    = 1'b1;                                  // this cycle fetches word 0
    endtask

    // starts in a fetch cycle and returns in the next fetch cycle
    task automatic stepInstr(output int cycles);
        cycles = 1;
        while (!retire) begin
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
    endtask

    task automatic stepCheck(string name, int expCycles, word_t expPc);
        int cycles;
        stepInstr(cycles);
        checkCycles(name, expCycles, cycles);
        checkWord({name, " pc"}, expPc, pc);
    endtask

    task automatic runSteps(string name, int n, int expCycles);
        int cycles;
        for (int i = 0; i < n; i++) begin
            stepInstr(cycles);
            checkCycles(name, expCycles, cycles);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic testArith();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [4:0]  s1;
        logic [4:0]  s2;
        word_t       a;
        word_t       b;
        immA = 16'($urandom());
        immB = 16'($urandom());
        immC = 16'($urandom());
        s1   = 5'($urandom());
        s2   = 5'($urandom());
        a    = sext16(immA);
        b    = {immB, immC};
        prog.delete();
        prog.push_back(iInstr(6'h08, 5'd0, 5'd1, immA));        // addi r1
        prog.push_back(iInstr(6'h0D, 5'd0, 5'd2, immB));        // ori r2 with the upper half
        prog.push_back(rInstr(6'h00, 5'd2, 5'd0, 5'd2, 5'd16));
        prog.push_back(iInstr(6'h0D, 5'd2, 5'd2, immC));
        prog.push_back(rInstr(6'h20, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h22, 5'd4, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h18, 5'd5, 5'd1, 5'd2, 5'd0));  // mult into rd
        prog.push_back(rInstr(6'h24, 5'd6, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h25, 5'd7, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h26, 5'd8, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h27, 5'd9, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h2A, 5'd10, 5'd1, 5'd2, 5'd0));
        prog.push_back(rInstr(6'h02, 5'd11, 5'd0, 5'd2, s1));
        prog.push_back(rInstr(6'h00, 5'd12, 5'd0, 5'd1, s2));
        loadAndStart();
        runSteps("arith", 14, 4);
        run = 1'b0;
        checkReg("addi const", 5'd1, a);
        checkReg("ori const", 5'd2, b);
        checkOp("add", 5'd3, opAdd, a, b, 5'd0);
        checkOp("sub", 5'd4, opSub, a, b, 5'd0);
        checkOp("mult", 5'd5, opMul, a, b, 5'd0);
        checkOp("and", 5'd6, opAnd, a, b, 5'd0);
        checkOp("or", 5'd7, opOr, a, b, 5'd0);
        checkOp("xor", 5'd8, opXor, a, b, 5'd0);
        checkOp("nor", 5'd9, opNor, a, b, 5'd0);
        checkOp("slt", 5'd10, opSlt, a, b, 5'd0);
        checkOp("srl", 5'd11, opSrl, '0, b, s1);
        checkOp("sll", 5'd12, opSll, '0, a, s2);
    endtask

    task automatic testLoadStore();
        logic [15:0] hi;
        logic [15:0] lo;
        logic [15:0] half;
        word_t       m;
        hi   = 16'($urandom());
        lo   = 16'($urandom());
        half = 16'($urandom()) | 16'h8080;              // sign set in both lanes
        m    = {hi, lo};                                // word after all three stores
        m[31:16] = half;
        m[15:8]  = half[7:0];
        prog.delete();
        prog.push_back(iInstr(6'h0D, 5'd0, 5'd1, 16'h0200));   // base at word 128
        prog.push_back(iInstr(6'h0D, 5'd0, 5'd2, hi));
        prog.push_back(rInstr(6'h00, 5'd2, 5'd0, 5'd2, 5'd16));
        prog.push_back(iInstr(6'h0D, 5'd2, 5'd2, lo));
        prog.push_back(iInstr(6'h08, 5'd0, 5'd3, half));
        prog.push_back(iInstr(6'h2B, 5'd1, 5'd2, 16'd0));      // sw
        prog.push_back(iInstr(6'h29, 5'd1, 5'd3, 16'd2));      // sh upper half
        prog.push_back(iInstr(6'h28, 5'd1, 5'd3, 16'd1));      // sb byte 1
        prog.push_back(iInstr(6'h23, 5'd1, 5'd4, 16'd0));      // lw
        prog.push_back(iInstr(6'h21, 5'd1, 5'd5, 16'd2));
        prog.push_back(iInstr(6'h20, 5'd1, 5'd6, 16'd1));
        prog.push_back(iInstr(6'h21, 5'd1, 5'd7, 16'd0));
        prog.push_back(iInstr(6'h20, 5'd1, 5'd8, 16'd0));
        loadAndStart();
        runSteps("store setup", 5, 4);
        runSteps("store", 3, 4);
        runSteps("load", 5, 5);
        run = 1'b0;
        checkReg("lw merged", 5'd4, m);
        checkReg("lh upper", 5'd5, sext16(m[31:16]));
        checkReg("lb byte 1", 5'd6, sext8(m[15:8]));
        checkReg("lh lower", 5'd7, sext16(m[15:0]));
        checkReg("lb byte 0", 5'd8, sext8(m[7:0]));
    endtask

    task automatic testBranches();
        word_t     br [12];
        bit [11:0] takenMask;
        word_t     brPc;
        takenMask = 12'b0101_0101_0101;                 // even cases are taken
        br[0]  = iInstr(6'h04, 5'd1, 5'd3, 16'd1);      // beq with r1 == r3
        br[1]  = iInstr(6'h04, 5'd1, 5'd2, 16'd1);
        br[2]  = iInstr(6'h05, 5'd1, 5'd2, 16'd1);      // bne
        br[3]  = iInstr(6'h05, 5'd1, 5'd3, 16'd1);
        br[4]  = iInstr(6'h01, 5'd1, 5'd1, 16'd1);      // bgez
        br[5]  = iInstr(6'h01, 5'd2, 5'd1, 16'd1);
        br[6]  = iInstr(6'h01, 5'd2, 5'd0, 16'd1);      // bltz
        br[7]  = iInstr(6'h01, 5'd1, 5'd0, 16'd1);
        br[8]  = iInstr(6'h07, 5'd1, 5'd0, 16'd1);      // bgtz
        br[9]  = iInstr(6'h07, 5'd0, 5'd0, 16'd1);
        br[10] = iInstr(6'h06, 5'd0, 5'd0, 16'd1);      // blez
        br[11] = iInstr(6'h06, 5'd1, 5'd0, 16'd1);
        prog.delete();
        prog.push_back(iInstr(6'h08, 5'd0, 5'd1, 16'd5));
        prog.push_back(iInstr(6'h08, 5'd0, 5'd2, 16'hFFFD));   // r2 = -3
        prog.push_back(iInstr(6'h08, 5'd0, 5'd3, 16'd5));
        for (int i = 0; i < 12; i++) begin
            prog.push_back(br[i]);
            prog.push_back(iInstr(6'h08, 5'd0, 5'(8 + i), 16'd1));  // fall-through marker
        end
        loadAndStart();
        runSteps("branch setup", 3, 4);
        for (int i = 0; i < 12; i++) begin
            brPc = word_t'(4 * (3 + 2 * i));
            if (takenMask[i]) begin
                stepCheck($sformatf("branch %0d taken", i), 3, brPc + 32'd8);
            end else begin
                stepCheck($sformatf("branch %0d not taken", i), 3, brPc + 32'd4);
                stepCheck($sformatf("branch %0d marker", i), 4, brPc + 32'd8);
            end
        end
        run = 1'b0;
        for (int i = 0; i < 12; i++) begin
            checkReg($sformatf("branch %0d r%0d", i, 8 + i), 5'(8 + i),
                     takenMask[i] ? 32'd0 : 32'd1);
        end
    endtask

    task automatic testJumps();
        prog.delete();
        prog.push_back(jInstr(6'h02, 26'd3));                  // j to word 3
        prog.push_back(iInstr(6'h08, 5'd0, 5'd5, 16'd1));      // skipped
        prog.push_back(iInstr(6'h08, 5'd0, 5'd5, 16'd2));
        prog.push_back(jInstr(6'h03, 26'd6));                  // jal to word 6
        prog.push_back(iInstr(6'h08, 5'd0, 5'd6, 16'd7));      // return lands here
        prog.push_back(32'h0000_0000);
        prog.push_back(iInstr(6'h08, 5'd0, 5'd7, 16'd3));
        prog.push_back(rInstr(6'h08, 5'd0, 5'd31, 5'd0, 5'd0)); // jr r31
        loadAndStart();
        stepCheck("j", 3, 32'h0000_000C);
        stepCheck("jal", 3, 32'h0000_0018);
        stepCheck("jal target", 4, 32'h0000_001C);
        stepCheck("jr", 3, 32'h0000_0010);
        stepCheck("return", 4, 32'h0000_0014);
        run = 1'b0;
        checkReg("jal link", 5'd31, 32'h0000_0010);
        checkReg("skipped", 5'd5, 32'd0);
        checkReg("after return", 5'd6, 32'd7);
        checkReg("jal target", 5'd7, 32'd3);
    endtask

    task automatic testNops();
        prog.delete();
        prog.push_back(iInstr(6'h08, 5'd0, 5'd1, 16'h1234));
        prog.push_back(32'h0000_0000);
        prog.push_back(iInstr(6'h3F, 5'd2, 5'd1, 16'hBEEF));   // undefined opcode
        prog.push_back(rInstr(6'h3F, 5'd5, 5'd1, 5'd1, 5'd0)); // undefined funct
        loadAndStart();
        for (int i = 0; i < 4; i++) begin
            stepCheck($sformatf("nop step %0d", i), 4, word_t'(4 * (i + 1)));
        end
        run = 1'b0;
        for (int r = 0; r < 32; r++) begin
            checkReg($sformatf("nop r%0d", r), 5'(r), (r == 1) ? 32'h1234 : 32'd0);
        end
    endtask

    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        dbgReg   = '0;
        void'($urandom(94118));
        testArith();
        testLoadStore();
        testBranches();
        testJumps();
        testNops();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
